/* Bender.yml */
package:
  name: frontend

sources:
  - fe_pkg.sv
  - fetch_align.sv
  - instr_scan.sv
  - cf_select.sv
  - npc_gen.sv
  - fetch_queue.sv
  - frontend.sv
  - target: simulation
    files:
      - frontend_checker.sv
      - frontend_props.sv
      - tb_frontend.sv

/* build.f */
fe_pkg.sv
fetch_align.sv
instr_scan.sv
cf_select.sv
npc_gen.sv
fetch_queue.sv
frontend.sv
frontend_checker.sv
frontend_props.sv
tb_frontend.sv

/* cf_select.sv */
// static prediction: picks the lowest taken slot, forms its target and masks later slots
`timescale 1ns/100ps

module cf_select import fe_pkg::*; (
    input  logic [INSTR_PER_FETCH-1:0]           slot_valid_i,
    input  logic [INSTR_PER_FETCH-1:0][XLEN-1:0] slot_addr_i,
    input  logic [INSTR_PER_FETCH-1:0]           is_branch_i,
    input  logic [INSTR_PER_FETCH-1:0]           is_jal_i,
    input  logic [INSTR_PER_FETCH-1:0][XLEN-1:0] imm_i,
    output logic                                 predict_valid_o,
    output logic [XLEN-1:0]                      predict_addr_o,
    output logic [INSTR_PER_FETCH-1:0]           push_valid_o,
    output logic [INSTR_PER_FETCH-1:0]           pred_taken_o
);

    logic [INSTR_PER_FETCH-1:0] taken;
    // set once a lower slot has left the sequential path
    logic                       blocked;

    // jal always, branch only when it points backwards
    for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_taken
        assign taken[i] = slot_valid_i[i] & (is_jal_i[i] | (is_branch_i[i] & imm_i[i][XLEN-1]));
    end

    // ------------------------------------------------------------------
    // lowest taken slot wins
    // ------------------------------------------------------------------
    always_comb begin
        blocked         = 1'b0;
        predict_valid_o = 1'b0;
        predict_addr_o  = '0;
        for (int i = 0; i < INSTR_PER_FETCH; i++) begin
            // slots behind a taken one are wrong path
            push_valid_o[i] = slot_valid_i[i] & ~blocked;
            pred_taken_o[i] = taken[i] & ~blocked;
            if (pred_taken_o[i]) begin
                predict_valid_o = 1'b1;
                predict_addr_o  = slot_addr_i[i] + imm_i[i];
                blocked         = 1'b1;
            end
        end
    end

endmodule

/* fe_pkg.sv */
// shared widths, opcodes, boot address and instruction views for the fetch front end
package fe_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN            = 32;
    localparam int unsigned ILEN            = 32;
    // one cache block carries two 32-bit instructions
    localparam int unsigned FETCH_WIDTH     = 64;
    localparam int unsigned INSTR_PER_FETCH = 2;
    // address bits [SLOT_IDX_W+1:2] select the slot inside a block
    localparam int unsigned SLOT_IDX_W      = 1;
    // byte offset bits of a block, cleared to form the block base
    localparam int unsigned BLOCK_OFFS_W    = SLOT_IDX_W + 2;

    // ------------------------------------------------------------------
    // fetch queue sizing
    // ------------------------------------------------------------------
    localparam int unsigned QUEUE_DEPTH     = 8;
    localparam int unsigned QPTR_W          = $clog2(QUEUE_DEPTH);
    localparam int unsigned QCNT_W          = $clog2(QUEUE_DEPTH + 1);
    // entries to keep free before a new request may leave:
    // one response in flight plus the new request, two slots each
    localparam int unsigned ROOM_MIN        = 2 * INSTR_PER_FETCH;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] BOOT_ADDR   = 32'h0000_0080;

    // major opcodes scanned for control flow
    localparam logic [6:0] OPC_BRANCH       = 7'b110_0011;
    localparam logic [6:0] OPC_JAL          = 7'b110_1111;

    // ------------------------------------------------------------------
    // one instruction word, seen as B-type or as J-type
    // ------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_t;

endpackage

/* fetch_align.sv */
// first front-end stage: registers the cache response and splits it into instruction slots
`timescale 1ns/100ps

module fetch_align import fe_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 npc_rst_load_q,
    // kill from redirect or taken prediction, drops the arriving response
    input  logic                                 flush_i,
    input  logic                                 icache_valid_i,
    input  logic [XLEN-1:0]                      icache_vaddr_i,
    input  logic [FETCH_WIDTH-1:0]               icache_data_i,
    output logic [INSTR_PER_FETCH-1:0]           slot_valid_o,
    output logic [INSTR_PER_FETCH-1:0][XLEN-1:0] slot_addr_o,
    output instr_t [INSTR_PER_FETCH-1:0]         slot_instr_o
);

    logic                   valid_q;
    logic [XLEN-1:0]        vaddr_q;
    logic [FETCH_WIDTH-1:0] data_q;
    // block base and first live slot of the registered response
    logic [XLEN-1:0]        base;
    logic [SLOT_IDX_W-1:0]  first_slot;

    // response valid, one response per cycle
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= icache_valid_i;
        end
    end

    // payload only moves on a valid response
    always_ff @(posedge clk_i) begin
        if (icache_valid_i) begin
            vaddr_q <= icache_vaddr_i;
            data_q  <= icache_data_i;
        end
    end

    assign base       = {vaddr_q[XLEN-1:BLOCK_OFFS_W], {BLOCK_OFFS_W{1'b0}}};
    assign first_slot = vaddr_q[BLOCK_OFFS_W-1:2];

    // ------------------------------------------------------------------
    // slot split
    // ------------------------------------------------------------------
    for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_slot
        // slots below the fetch address belong to the previous path
        assign slot_valid_o[i] = valid_q & (SLOT_IDX_W'(i) >= first_slot);
        assign slot_addr_o[i]  = base + XLEN'(4 * i);
        // lower word is the lower address
        assign slot_instr_o[i] = data_q[ILEN*i +: ILEN];
    end

endmodule

/* fetch_queue.sv */
// fetch entry FIFO: takes up to two slots per cycle, drains by valid/ready, gates requests
`timescale 1ns/100ps

module fetch_queue import fe_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 npc_rst_load_q,
    // back-end redirect empties the queue
    input  logic                                 flush_i,
    input  logic [INSTR_PER_FETCH-1:0]           push_valid_i,
    input  logic [INSTR_PER_FETCH-1:0][XLEN-1:0] push_addr_i,
    input  logic [INSTR_PER_FETCH-1:0][ILEN-1:0] push_instr_i,
    input  logic [INSTR_PER_FETCH-1:0]           push_taken_i,
    input  logic                                 fetch_ready_i,
    output logic                                 fetch_valid_o,
    output logic [XLEN-1:0]                      fetch_pc_o,
    output logic [ILEN-1:0]                      fetch_instr_o,
    output logic                                 fetch_pred_taken_o,
    output logic                                 room_o
);

    // entry storage
    logic [XLEN-1:0]                         pc_mem    [QUEUE_DEPTH];
    logic [ILEN-1:0]                         instr_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0]                  taken_mem;
    logic [QPTR_W-1:0]                       rptr_q;
    logic [QPTR_W-1:0]                       wptr_q;
    logic [QCNT_W-1:0]                       count_q;
    logic [QCNT_W-1:0]                       n_push;
    logic [INSTR_PER_FETCH-1:0][QPTR_W-1:0]  wr_idx;
    logic                                    pop;
    // low for the first cycle after reset so no request leaves early
    logic                                    run_q;

    // ------------------------------------------------------------------
    // push compaction
    // ------------------------------------------------------------------
    // valid slots are packed in slot order from the write pointer
    always_comb begin
        n_push = '0;
        for (int i = 0; i < INSTR_PER_FETCH; i++) begin
            wr_idx[i] = wptr_q + n_push[QPTR_W-1:0];
            n_push    = n_push + QCNT_W'(push_valid_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < INSTR_PER_FETCH; i++) begin
            if (push_valid_i[i]) begin
                pc_mem[wr_idx[i]]    <= push_addr_i[i];
                instr_mem[wr_idx[i]] <= push_instr_i[i];
                taken_mem[wr_idx[i]] <= push_taken_i[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= '0;
            run_q   <= 1'b0;
        end else if (flush_i) begin
            // pushes of this cycle are old path as well
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= '0;
            run_q   <= 1'b1;
        end else begin
            rptr_q  <= rptr_q + QPTR_W'(pop);
            wptr_q  <= wptr_q + n_push[QPTR_W-1:0];
            count_q <= count_q + n_push - QCNT_W'(pop);
            run_q   <= 1'b1;
        end
    end

    // output side
    assign fetch_valid_o      = (count_q != '0) & ~flush_i;
    assign pop                = fetch_valid_o & fetch_ready_i;
    assign fetch_pc_o         = pc_mem[rptr_q];
    assign fetch_instr_o      = instr_mem[rptr_q];
    assign fetch_pred_taken_o = taken_mem[rptr_q];

    // free space after this cycle's pushes must hold the response
    // still in flight and the new request, pops not counted
    assign room_o = run_q & ((QCNT_W'(QUEUE_DEPTH) - count_q - n_push) >= QCNT_W'(ROOM_MIN));

endmodule

/* frontend.sv */
// fetch front-end top: cache request, slot scan, static prediction, redirect and fetch queue
`timescale 1ns/100ps

module frontend import fe_pkg::*; (
    input  logic                   clk_i,
    input  logic                   npc_rst_load_q,
    // instruction cache request and response
    output logic                   icache_req_o,
    output logic [XLEN-1:0]        icache_vaddr_o,
    output logic                   icache_kill_o,
    input  logic                   icache_ready_i,
    input  logic                   icache_valid_i,
    input  logic [FETCH_WIDTH-1:0] icache_data_i,
    input  logic [XLEN-1:0]        icache_vaddr_i,
    // back-end control flow change
    input  logic                   redirect_i,
    input  logic [XLEN-1:0]        redirect_pc_i,
    // fetch entries towards decode
    output logic                   fetch_valid_o,
    input  logic                   fetch_ready_i,
    output logic [XLEN-1:0]        fetch_pc_o,
    output logic [ILEN-1:0]        fetch_instr_o,
    output logic                   fetch_pred_taken_o
);

    logic [INSTR_PER_FETCH-1:0]           slot_valid;
    logic [INSTR_PER_FETCH-1:0][XLEN-1:0] slot_addr;
    instr_t [INSTR_PER_FETCH-1:0]         slot_instr;
    logic [INSTR_PER_FETCH-1:0]           is_branch;
    logic [INSTR_PER_FETCH-1:0]           is_jal;
    logic [INSTR_PER_FETCH-1:0][XLEN-1:0] imm;
    logic                                 predict_valid;
    logic [XLEN-1:0]                      predict_addr;
    logic [INSTR_PER_FETCH-1:0]           push_valid;
    logic [INSTR_PER_FETCH-1:0]           pred_taken;
    logic                                 room;
    logic                                 req_fire;

    // ------------------------------------------------------------------
    // cache handshake
    // ------------------------------------------------------------------
    assign icache_req_o  = room;
    assign req_fire      = icache_req_o & icache_ready_i;
    // kills this cycle's request, fetch_align also drops the arriving response
    assign icache_kill_o = redirect_i | predict_valid;

    fetch_align i_fetch_align (
        .clk_i          ( clk_i          ),
        .npc_rst_load_q ( npc_rst_load_q ),
        .flush_i        ( icache_kill_o  ),
        .icache_valid_i ( icache_valid_i ),
        .icache_vaddr_i ( icache_vaddr_i ),
        .icache_data_i  ( icache_data_i  ),
        .slot_valid_o   ( slot_valid     ),
        .slot_addr_o    ( slot_addr      ),
        .slot_instr_o   ( slot_instr     )
    );

    // one scanner per slot
    for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_instr_scan
        instr_scan i_instr_scan (
            .instr_i     ( slot_instr[i] ),
            .is_branch_o ( is_branch[i]  ),
            .is_jal_o    ( is_jal[i]     ),
            .imm_o       ( imm[i]        )
        );
    end

    cf_select i_cf_select (
        .slot_valid_i    ( slot_valid    ),
        .slot_addr_i     ( slot_addr     ),
        .is_branch_i     ( is_branch     ),
        .is_jal_i        ( is_jal        ),
        .imm_i           ( imm           ),
        .predict_valid_o ( predict_valid ),
        .predict_addr_o  ( predict_addr  ),
        .push_valid_o    ( push_valid    ),
        .pred_taken_o    ( pred_taken    )
    );

    npc_gen i_npc_gen (
        .clk_i           ( clk_i          ),
        .npc_rst_load_q  ( npc_rst_load_q ),
        .req_fire_i      ( req_fire       ),
        .predict_valid_i ( predict_valid  ),
        .predict_addr_i  ( predict_addr   ),
        .redirect_i      ( redirect_i     ),
        .redirect_pc_i   ( redirect_pc_i  ),
        .fetch_addr_o    ( icache_vaddr_o )
    );

    fetch_queue i_fetch_queue (
        .clk_i              ( clk_i              ),
        .npc_rst_load_q     ( npc_rst_load_q     ),
        .flush_i            ( redirect_i         ),
        .push_valid_i       ( push_valid         ),
        .push_addr_i        ( slot_addr          ),
        .push_instr_i       ( slot_instr         ),
        .push_taken_i       ( pred_taken         ),
        .fetch_ready_i      ( fetch_ready_i      ),
        .fetch_valid_o      ( fetch_valid_o      ),
        .fetch_pc_o         ( fetch_pc_o         ),
        .fetch_instr_o      ( fetch_instr_o      ),
        .fetch_pred_taken_o ( fetch_pred_taken_o ),
        .room_o             ( room               )
    );

endmodule

/* frontend_checker.sv */
// testbench checker: runs the fetch reference model and compares every accepted entry
`timescale 1ns/100ps

module frontend_checker import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            npc_rst_load_q,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic            fetch_valid_i,
    input  logic            fetch_ready_i,
    input  logic [XLEN-1:0] fetch_pc_i,
    input  logic [ILEN-1:0] fetch_instr_i,
    input  logic            fetch_taken_i,
    // name of the running test and its closing strobe
    input  logic [31:0]     test_name_i,
    input  logic            test_end_i,
    output logic [31:0]     seg_count_o,
    output logic [31:0]     pass_cnt_o,
    output logic [31:0]     fail_cnt_o
);

    // pc the next accepted entry must carry
    logic [XLEN-1:0] model_pc;
    int unsigned     seg_errs;

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name_i, field, exp, act);
            seg_errs++;
        end
    endtask

    // ------------------------------------------------------------------
    // reference model for one accepted entry
    // ------------------------------------------------------------------
    task automatic check_entry();
        instr_t                 w;
        logic signed [XLEN-1:0] offs;
        logic                   taken;
        w     = tb_frontend.prog_mem[model_pc[9:2]];
        offs  = '0;
        taken = 1'b0;
        if (w.j.opcode == OPC_JAL) begin
            // jal is always followed
            offs  = $signed({w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0});
            taken = 1'b1;
        end else if (w.b.opcode == OPC_BRANCH) begin
            // backward taken, forward not taken
            offs  = $signed({w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0});
            taken = offs[XLEN-1];
        end
        compare_field("pc", model_pc, fetch_pc_i);
        compare_field("instr", w, fetch_instr_i);
        compare_field("taken", 32'(taken), 32'(fetch_taken_i));
        model_pc    = taken ? model_pc + offs : model_pc + 32'd4;
        seg_count_o = seg_count_o + 1;
    endtask

    // one line per finished test
    task automatic close_test();
        if (seg_errs == 0) begin
            $display("test %s passed, %0d entries", test_name_i, seg_count_o);
            pass_cnt_o = pass_cnt_o + 1;
        end else begin
            $display("test %s failed, %0d errors", test_name_i, seg_errs);
            fail_cnt_o = fail_cnt_o + 1;
        end
        seg_errs = 0;
    endtask

    always @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            model_pc    = BOOT_ADDR;
            seg_count_o = '0;
            seg_errs    = 0;
            pass_cnt_o  = '0;
            fail_cnt_o  = '0;
        end else begin
            if (fetch_valid_i && fetch_ready_i) begin
                check_entry();
            end
            if (test_end_i) begin
                close_test();
            end
            // back end restart, old path entries must not follow
            if (redirect_i) begin
                model_pc    = redirect_pc_i;
                seg_count_o = '0;
            end
        end
    end

endmodule

/* frontend_input.txt */
// table from word 0: test name (four ASCII chars), entries to accept, start address
// program words follow as @word_address value; every other word keeps the filler
@00
626f6f74 00000006 00000080
7365715f 0000000a 00000104
62726368 0000000c 00000140
6a616c5f 0000000c 00000180
72656472 00000004 0000020c
626b7072 000000c8 00000240
00000000 00000000 00000000
// brch: beq +16 at 0x148 falls through, bne -16 at 0x154 loops to 0x144
@52 00208863
@55 fe2098e3
// jal_: jal +0x38 at 0x188 to 0x1c0, jal -0x44 at 0x1c4 back to 0x180
@62 0380006f
@71 fbdff06f
// bkpr: beq +8 at 0x254, jal +8 at 0x260 skips 0x264, jal -0x3c at 0x27c to 0x240
@95 00208463
@98 0080006f
@9f fc5ff06f

/* frontend_props.sv */
// concurrent assertions on the front-end handshakes that are bound into frontend
`timescale 1ns/100ps

module frontend_props import fe_pkg::*; (
    input logic            clk_i,
    input logic            npc_rst_load_q,
    input logic            redirect_i,
    input logic            icache_req_i,
    input logic            fetch_valid_i,
    input logic            fetch_ready_i,
    input logic [XLEN-1:0] fetch_pc_i,
    input logic [ILEN-1:0] fetch_instr_i,
    input logic            fetch_taken_i
);

    // queue stays empty through reset
    assert property (@(posedge clk_i) npc_rst_load_q ##1 npc_rst_load_q |-> !fetch_valid_i)
        else $error("fetch_valid_o high during reset");

    // stalled entry holds until it transfers or a redirect flushes it
    assert property (@(posedge clk_i) disable iff (npc_rst_load_q)
        fetch_valid_i && !fetch_ready_i |=> redirect_i || (fetch_valid_i &&
            $stable(fetch_pc_i) && $stable(fetch_instr_i) && $stable(fetch_taken_i)))
        else $error("fetch entry changed under back-pressure");

    // no cache request in the cycle after any reset edge
    assert property (@(posedge clk_i) npc_rst_load_q |=> !icache_req_i)
        else $error("icache_req_o high right after a reset edge");

endmodule

bind frontend frontend_props i_frontend_props (
    .clk_i          ( clk_i              ),
    .npc_rst_load_q ( npc_rst_load_q     ),
    .redirect_i     ( redirect_i         ),
    .icache_req_i   ( icache_req_o       ),
    .fetch_valid_i  ( fetch_valid_o      ),
    .fetch_ready_i  ( fetch_ready_i      ),
    .fetch_pc_i     ( fetch_pc_o         ),
    .fetch_instr_i  ( fetch_instr_o      ),
    .fetch_taken_i  ( fetch_pred_taken_o )
);

/* instr_scan.sv */
// per-slot scanner: flags conditional branches and JAL and rebuilds their offset
`timescale 1ns/100ps

module instr_scan import fe_pkg::*; (
    input  instr_t          instr_i,
    output logic            is_branch_o,
    output logic            is_jal_o,
    output logic [XLEN-1:0] imm_o
);

    // offsets as decoded from each view of the word
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    // ------------------------------------------------------------------
    // opcode match
    // ------------------------------------------------------------------
    // opcode sits at the same place in both views
    assign is_branch_o = (instr_i.b.opcode == OPC_BRANCH);
    assign is_jal_o    = (instr_i.j.opcode == OPC_JAL);

    // ------------------------------------------------------------------
    // immediate reassembly
    // ------------------------------------------------------------------
    // B-type, 13-bit byte offset, bit 0 always zero
    assign imm_b = {
        {(XLEN-12){instr_i.b.imm12}},
        instr_i.b.imm11,
        instr_i.b.imm10_5,
        instr_i.b.imm4_1,
        1'b0
    };

    // J-type, 21-bit byte offset, bit 0 always zero
    assign imm_j = {
        {(XLEN-20){instr_i.j.imm20}},
        instr_i.j.imm19_12,
        instr_i.j.imm11,
        instr_i.j.imm10_1,
        1'b0
    };

    // jal takes the J view, anything else the B view
    assign imm_o = is_jal_o ? imm_j : imm_b;

endmodule

/* npc_gen.sv */
// next fetch PC: boot load, redirect, static prediction and sequential block advance
`timescale 1ns/100ps

module npc_gen import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            npc_rst_load_q,
    // request accepted by the cache this cycle
    input  logic            req_fire_i,
    input  logic            predict_valid_i,
    input  logic [XLEN-1:0] predict_addr_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    output logic [XLEN-1:0] fetch_addr_o
);

    logic [XLEN-1:0] npc_d;
    logic [XLEN-1:0] npc_q;

    // ------------------------------------------------------------------
    // next PC select
    // ------------------------------------------------------------------
    // lowest priority first, later assignments override
    always_comb begin
        fetch_addr_o = npc_q;
        npc_d        = npc_q;
        if (predict_valid_i) begin
            // prediction also steers the address leaving this cycle
            fetch_addr_o = predict_addr_i;
            npc_d        = predict_addr_i;
        end else if (req_fire_i) begin
            // step to the next aligned block
            npc_d = {npc_q[XLEN-1:BLOCK_OFFS_W], {BLOCK_OFFS_W{1'b0}}} + XLEN'(FETCH_WIDTH / 8);
        end
        // back end overrides any local guess
        if (redirect_i) begin
            npc_d = redirect_pc_i;
        end
    end

    // reset loads the boot address on the next edge
    always_ff @(posedge clk_i) begin
        if (npc_rst_load_q) begin
            npc_q <= BOOT_ADDR;
        end else begin
            npc_q <= npc_d;
        end
    end

endmodule

/* tb_frontend.sv */
// testbench top for the fetch front end: clock, reset, cache model, redirect schedule, summary
`timescale 1ns/100ps

module tb_frontend import fe_pkg::*; ();

    logic                   clk_i = 1'b0;
    logic                   npc_rst_load_q;
    logic                   icache_req_o;
    logic [XLEN-1:0]        icache_vaddr_o;
    logic                   icache_kill_o;
    logic                   icache_ready_i;
    logic                   icache_valid_i;
    logic [FETCH_WIDTH-1:0] icache_data_i;
    logic [XLEN-1:0]        icache_vaddr_i;
    logic                   redirect_i;
    logic [XLEN-1:0]        redirect_pc_i;
    logic                   fetch_valid_o;
    logic                   fetch_ready_i;
    logic [XLEN-1:0]        fetch_pc_o;
    logic [ILEN-1:0]        fetch_instr_o;
    logic                   fetch_pred_taken_o;

    // program image, word indexed, the checker reads it too
    logic [31:0]            prog_mem [256];
    // request accepted and not killed, answered in the next cycle
    logic                   resp_pend_q;
    logic [XLEN-1:0]        resp_addr_q;
    logic                   seeded = 1'b0;
    logic                   timed_out;
    // running test, four ASCII characters
    logic [31:0]            test_name;
    logic                   test_end;
    logic [31:0]            seg_count;
    logic [31:0]            pass_cnt;
    logic [31:0]            fail_cnt;

    always #5 clk_i = ~clk_i;

    frontend i_dut (
        .clk_i              ( clk_i              ),
        .npc_rst_load_q     ( npc_rst_load_q     ),
        .icache_req_o       ( icache_req_o       ),
        .icache_vaddr_o     ( icache_vaddr_o     ),
        .icache_kill_o      ( icache_kill_o      ),
        .icache_ready_i     ( icache_ready_i     ),
        .icache_valid_i     ( icache_valid_i     ),
        .icache_data_i      ( icache_data_i      ),
        .icache_vaddr_i     ( icache_vaddr_i     ),
        .redirect_i         ( redirect_i         ),
        .redirect_pc_i      ( redirect_pc_i      ),
        .fetch_valid_o      ( fetch_valid_o      ),
        .fetch_ready_i      ( fetch_ready_i      ),
        .fetch_pc_o         ( fetch_pc_o         ),
        .fetch_instr_o      ( fetch_instr_o      ),
        .fetch_pred_taken_o ( fetch_pred_taken_o )
    );

    frontend_checker i_checker (
        .clk_i          ( clk_i              ),
        .npc_rst_load_q ( npc_rst_load_q     ),
        .redirect_i     ( redirect_i         ),
        .redirect_pc_i  ( redirect_pc_i      ),
        .fetch_valid_i  ( fetch_valid_o      ),
        .fetch_ready_i  ( fetch_ready_i      ),
        .fetch_pc_i     ( fetch_pc_o         ),
        .fetch_instr_i  ( fetch_instr_o      ),
        .fetch_taken_i  ( fetch_pred_taken_o ),
        .test_name_i    ( test_name          ),
        .test_end_i     ( test_end           ),
        .seg_count_o    ( seg_count          ),
        .pass_cnt_o     ( pass_cnt           ),
        .fail_cnt_o     ( fail_cnt           )
    );

    // ------------------------------------------------------------------
    // cache model
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        resp_pend_q <= !npc_rst_load_q && icache_req_o && icache_ready_i && !icache_kill_o;
        resp_addr_q <= icache_vaddr_o;
    end

    // response and both ready lines move on the falling edge
    always @(negedge clk_i) begin
        if (!seeded) begin
            void'($urandom(32'h95d4_3653));
            seeded = 1'b1;
        end
        icache_valid_i <= resp_pend_q;
        icache_vaddr_i <= resp_addr_q;
        // lower word is the lower address
        icache_data_i  <= {prog_mem[{resp_addr_q[9:3], 1'b1}], prog_mem[{resp_addr_q[9:3], 1'b0}]};
        icache_ready_i <= ($urandom % 4) != 0;
        fetch_ready_i  <= ($urandom % 3) != 0;
    end

    // falling-edge wait until the running test has seen n entries
    task automatic wait_entries(input logic [31:0] n);
        int unsigned cycles;
        cycles = 0;
        while (seg_count < n && !timed_out) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > 5000) begin
                $display("timed out waiting for fetch entry");
                timed_out = 1'b1;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // test schedule
    // ------------------------------------------------------------------
    initial begin
        int unsigned k;
        npc_rst_load_q = 1'b1;
        redirect_i     = 1'b0;
        redirect_pc_i  = '0;
        icache_ready_i = 1'b0;
        icache_valid_i = 1'b0;
        icache_vaddr_i = '0;
        icache_data_i  = '0;
        fetch_ready_i  = 1'b0;
        test_end       = 1'b0;
        timed_out      = 1'b0;
        // filler is an addi whose upper bits hold the word address
        for (int i = 0; i < 256; i++) begin
            prog_mem[i] = {i[24:0], 7'h13};
        end
        $readmemh("frontend_input.txt", prog_mem);
        test_name = prog_mem[0];
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        npc_rst_load_q = 1'b0;
        // first row runs from the boot address
        wait_entries(prog_mem[1]);
        k = 1;
        while (prog_mem[3*k] != '0 && !timed_out) begin
            // close the running test and restart fetch in one cycle
            test_end      = 1'b1;
            redirect_i    = 1'b1;
            redirect_pc_i = prog_mem[3*k+2];
            @(negedge clk_i);
            test_end      = 1'b0;
            redirect_i    = 1'b0;
            test_name     = prog_mem[3*k];
            wait_entries(prog_mem[3*k+1]);
            k++;
        end
        test_end = 1'b1;
        @(negedge clk_i);
        test_end = 1'b0;
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (timed_out || fail_cnt != 0) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule
